//--- rtl/axi_rd_config.svh
`ifndef AXI_RD_CONFIG_SVH
`define AXI_RD_CONFIG_SVH

// Bus widths, fixed per build
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_LEN_W  8

// Native write credits granted after reset
`define WR_CREDITS 4

`define AXI_BYTES (`AXI_DATA_W / 8)

`endif

//--- rtl/axi_pkg.sv
`include "axi_rd_config.svh"

package axi_pkg;

   typedef enum logic [1:0] {
      FIXED = 2'd0,
      INCR  = 2'd1,
      WRAP  = 2'd2
   } axi_burst_e;

   typedef enum logic [1:0] {
      OKAY   = 2'd0,
      EXOKAY = 2'd1,
      SLVERR = 2'd2,
      DECERR = 2'd3
   } axi_resp_e;

   // Read address channel, master to slave
   typedef struct packed {
      logic                  arvalid;
      logic [`AXI_ADDR_W-1:0] araddr;
      logic [`AXI_LEN_W-1:0]  arlen;
      logic [2:0]             arsize;
      axi_burst_e             arburst;
   } axi_ar_t;

   // Read data channel, slave to master
   typedef struct packed {
      logic                   rvalid;
      logic [`AXI_DATA_W-1:0] rdata;
      axi_resp_e              rresp;
      logic                   rlast;
   } axi_r_t;

endpackage

//--- rtl/xfer_pkg.sv
`include "axi_rd_config.svh"

package xfer_pkg;

   // Transfer command from the control port
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;
      logic [`AXI_LEN_W-1:0]  len;
   } xfer_req_t;

   // One native memory write
   typedef struct packed {
      logic                   valid;
      logic [`AXI_ADDR_W-1:0] addr;
      logic [`AXI_DATA_W-1:0] wdata;
      logic [`AXI_BYTES-1:0]  wstrb;
   } wr_beat_t;

   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      ADDR_HS = 2'd1,
      READ    = 2'd2
   } ctrl_state_e;

endpackage

//--- rtl/rd_burst_ctrl.sv
`timescale 1ns/1ns
`include "axi_rd_config.svh"

module rd_burst_ctrl (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  run_i,
   input  logic [`AXI_LEN_W-1:0] len_i,
   input  logic                  ar_done_i,
   input  axi_pkg::axi_r_t       r_i,
   input  logic                  has_credit_i,
   output logic                  start_o,
   output logic                  rready_o,
   output logic                  beat_o,
   output logic                  ready_o,
   output logic                  error_o
);

   xfer_pkg::ctrl_state_e state_q;
   xfer_pkg::ctrl_state_e state_d;

   logic [`AXI_LEN_W-1:0] len_q;
   logic [`AXI_LEN_W-1:0] count_q;
   logic                  last_beat;
   logic                  beat_err;
   logic                  err_q;

   assign start_o = (state_q == xfer_pkg::IDLE) && run_i && ready_o;

   // No credit left means the sink could overflow, so stall R
   assign rready_o = (state_q == xfer_pkg::READ) && has_credit_i;
   assign beat_o   = r_i.rvalid && rready_o;

   assign last_beat = (count_q == len_q);

   // rlast must line up with the final beat, in either direction
   assign beat_err = (r_i.rresp != axi_pkg::OKAY) || (r_i.rlast != last_beat);

   always_comb begin
      state_d = state_q;
      case (state_q)
         xfer_pkg::IDLE: begin
            if (start_o) begin
               state_d = xfer_pkg::ADDR_HS;
            end
         end
         xfer_pkg::ADDR_HS: begin
            if (ar_done_i) begin
               state_d = xfer_pkg::READ;
            end
         end
         xfer_pkg::READ: begin
            if (beat_o && last_beat) begin
               state_d = xfer_pkg::IDLE;
            end
         end
         default: begin
            state_d = xfer_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         state_q <= xfer_pkg::IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_o) begin
         len_q <= len_i;
      end
   end

   // Beat count and error accumulation
   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         count_q <= '0;
         err_q   <= 1'b0;
         ready_o <= 1'b1;
         error_o <= 1'b0;
      end else if (start_o) begin
         count_q <= '0;
         err_q   <= 1'b0;
         ready_o <= 1'b0;
         error_o <= 1'b0;
      end else if (beat_o) begin
         count_q <= count_q + 1'b1;
         err_q   <= err_q | beat_err;
         if (last_beat) begin
            ready_o <= 1'b1;
            error_o <= err_q | beat_err;
         end
      end
   end

endmodule

//--- rtl/ar_channel.sv
`timescale 1ns/1ns
`include "axi_rd_config.svh"

module ar_channel (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                start_i,
   input  xfer_pkg::xfer_req_t req_i,
   input  logic                arready_i,
   output axi_pkg::axi_ar_t    ar_o,
   output logic                ar_done_o
);

   logic                   arvalid_q;
   logic [`AXI_ADDR_W-1:0] araddr_q;
   logic [`AXI_LEN_W-1:0]  arlen_q;

   assign ar_done_o = arvalid_q && arready_i;

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         arvalid_q <= 1'b0;
      end else if (start_i) begin
         arvalid_q <= 1'b1;
      end else if (ar_done_o) begin
         arvalid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         araddr_q <= req_i.addr;
         arlen_q  <= req_i.len;
      end
   end

   always_comb begin
      ar_o.arvalid = arvalid_q;
      ar_o.araddr  = araddr_q;
      ar_o.arlen   = arlen_q;
      // Full-width beats only
      ar_o.arsize  = 3'($clog2(`AXI_BYTES));
      ar_o.arburst = axi_pkg::INCR;
   end

endmodule

//--- rtl/wr_addr_gen.sv
`timescale 1ns/1ns
`include "axi_rd_config.svh"

module wr_addr_gen (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   start_i,
   input  logic [`AXI_ADDR_W-1:0] base_i,
   input  logic                   beat_i,
   input  logic [`AXI_DATA_W-1:0] rdata_i,
   output xfer_pkg::wr_beat_t     wr_o
);

   logic [`AXI_ADDR_W-1:0] addr_q;
   logic                   valid_q;
   logic [`AXI_ADDR_W-1:0] wr_addr_q;
   logic [`AXI_DATA_W-1:0] wdata_q;

   // Address of the next beat to arrive
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         addr_q <= base_i;
      end else if (beat_i) begin
         addr_q <= addr_q + `AXI_ADDR_W'(`AXI_BYTES);
      end
   end

   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= beat_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (beat_i) begin
         wr_addr_q <= addr_q;
         wdata_q   <= rdata_i;
      end
   end

   always_comb begin
      wr_o.valid = valid_q;
      wr_o.addr  = wr_addr_q;
      wr_o.wdata = wdata_q;
      wr_o.wstrb = '1;
   end

endmodule

//--- rtl/credit_counter.sv
`timescale 1ns/1ns
`include "axi_rd_config.svh"

module credit_counter (
   input  logic clk_i,
   input  logic rst_i,
   input  logic beat_i,
   input  logic credit_i,
   output logic has_credit_o
);

   localparam int CNT_W = $clog2(`WR_CREDITS + 1);

   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`WR_CREDITS);

   logic [CNT_W-1:0] count_q;

   // Credit is taken when the beat is accepted, before it shows on wr_o
   always_ff @(posedge clk_i, posedge rst_i) begin
      if (rst_i) begin
         count_q <= CNT_MAX;
      end else begin
         case ({beat_i, credit_i})
            2'b10: begin
               if (count_q != '0) begin
                  count_q <= count_q - 1'b1;
               end
            end
            2'b01: begin
               if (count_q != CNT_MAX) begin
                  count_q <= count_q + 1'b1;
               end
            end
            // Consume and return together cancel out
            default: begin
               count_q <= count_q;
            end
         endcase
      end
   end

   assign has_credit_o = (count_q != '0);

endmodule

//--- rtl/axi_rd_dma.sv
`timescale 1ns/1ns

module axi_rd_dma (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                run_i,
   input  xfer_pkg::xfer_req_t req_i,
   output logic                ready_o,
   output logic                error_o,
   output axi_pkg::axi_ar_t    ar_o,
   input  logic                arready_i,
   input  axi_pkg::axi_r_t     r_i,
   output logic                rready_o,
   output xfer_pkg::wr_beat_t  wr_o,
   input  logic                credit_i
);

   logic start;
   logic ar_done;
   logic has_credit;
   logic beat;

   rd_burst_ctrl u_ctrl (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .run_i       (run_i),
      .len_i       (req_i.len),
      .ar_done_i   (ar_done),
      .r_i         (r_i),
      .has_credit_i(has_credit),
      .start_o     (start),
      .rready_o    (rready_o),
      .beat_o      (beat),
      .ready_o     (ready_o),
      .error_o     (error_o)
   );

   ar_channel u_ar (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .start_i  (start),
      .req_i    (req_i),
      .arready_i(arready_i),
      .ar_o     (ar_o),
      .ar_done_o(ar_done)
   );

   wr_addr_gen u_addr_gen (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .start_i(start),
      .base_i (req_i.addr),
      .beat_i (beat),
      .rdata_i(r_i.rdata),
      .wr_o   (wr_o)
   );

   credit_counter u_credits (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .beat_i      (beat),
      .credit_i    (credit_i),
      .has_credit_o(has_credit)
   );

endmodule

//--- verif/axi_mem_model.sv
`timescale 1ns/1ns
`include "axi_rd_config.svh"

module axi_mem_model #(
   parameter logic [`AXI_DATA_W-1:0] DATA_XOR = 32'h0
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  axi_pkg::axi_ar_t      ar_i,
   output logic                  arready_o,
   output axi_pkg::axi_r_t       r_o,
   input  logic                  rready_i,
   input  logic                  err_en_i,
   input  logic [`AXI_LEN_W-1:0] err_beat_i,
   input  logic                  drop_last_i
);

   int unsigned            rand_state;
   logic                   ar_hs;
   logic                   r_hs;
   logic                   busy;
   logic [`AXI_ADDR_W-1:0] base;
   logic [`AXI_LEN_W:0]    len;
   logic [`AXI_LEN_W:0]    idx;
   logic [`AXI_ADDR_W-1:0] beat_addr;

   function int unsigned next_rand();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state >> 16;
   endfunction

   initial begin
      rand_state = 57831;
      arready_o  = 1'b0;
      r_o        = '0;
      busy       = 1'b0;
      idx        = '0;
      len        = '0;
      base       = '0;
   end

   // Handshakes sampled mid-cycle, outputs driven just after the edge
   always begin
      @(negedge clk_i);
      ar_hs = ar_i.arvalid && arready_o;
      r_hs  = r_o.rvalid && rready_i;
      @(posedge clk_i);
      #2;
      if (rst_i) begin
         arready_o = 1'b0;
         r_o       = '0;
         busy      = 1'b0;
      end else begin
         if (ar_hs) begin
            base      = ar_i.araddr;
            len       = {1'b0, ar_i.arlen};
            idx       = '0;
            busy      = 1'b1;
            arready_o = 1'b0;
         end else begin
            arready_o = ar_i.arvalid && !busy && (next_rand() % 3 == 0);
         end
         if (r_hs && busy) begin
            if (idx == len) begin
               busy = 1'b0;
            end
            idx = idx + 1'b1;
         end
         if (!busy) begin
            r_o.rvalid = 1'b0;
         end else if (!(r_o.rvalid && !r_hs)) begin
            beat_addr  = base + `AXI_ADDR_W'(idx * `AXI_BYTES);
            r_o.rvalid = (next_rand() % 4 != 0);
            r_o.rdata  = beat_addr ^ DATA_XOR;
            r_o.rresp  = (err_en_i && idx == {1'b0, err_beat_i}) ? axi_pkg::SLVERR
                                                                  : axi_pkg::OKAY;
            r_o.rlast  = (idx == len) && !drop_last_i;
         end
      end
   end

endmodule

//--- verif/tb_axi_rd_dma.sv
`timescale 1ns/1ns
`include "axi_rd_config.svh"

module tb_axi_rd_dma;

   localparam logic [`AXI_DATA_W-1:0] DATA_XOR = 32'hA5C3_0F96;
   localparam int TIMEOUT_CYCLES = 500;

   logic                clk_i;
   logic                rst_i;
   logic                run_i;
   xfer_pkg::xfer_req_t req_i;
   logic                ready_o;
   logic                error_o;
   axi_pkg::axi_ar_t    ar_o;
   logic                arready_i;
   axi_pkg::axi_r_t     r_i;
   logic                rready_o;
   xfer_pkg::wr_beat_t  wr_o;
   logic                credit_i;

   logic                  err_en;
   logic [`AXI_LEN_W-1:0] err_beat;
   logic                  drop_last;
   logic                  hold_credits;

   int unsigned            rand_state;
   int                     wr_idx;
   int                     outstanding;
   logic                   wr_seen;
   logic                   give_credit;
   logic [`AXI_ADDR_W-1:0] exp_base;
   logic [`AXI_LEN_W-1:0]  exp_len;
   logic [`AXI_ADDR_W-1:0] exp_wr_addr;

   assign exp_wr_addr = exp_base + `AXI_ADDR_W'(wr_idx * `AXI_BYTES);

   axi_rd_dma dut_i (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .run_i    (run_i),
      .req_i    (req_i),
      .ready_o  (ready_o),
      .error_o  (error_o),
      .ar_o     (ar_o),
      .arready_i(arready_i),
      .r_i      (r_i),
      .rready_o (rready_o),
      .wr_o     (wr_o),
      .credit_i (credit_i)
   );

   axi_mem_model #(.DATA_XOR(DATA_XOR)) u_mem (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ar_i       (ar_o),
      .arready_o  (arready_i),
      .r_o        (r_i),
      .rready_i   (rready_o),
      .err_en_i   (err_en),
      .err_beat_i (err_beat),
      .drop_last_i(drop_last)
   );

   always #10 clk_i = ~clk_i;

   function int unsigned next_rand();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state >> 16;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Some tests failed");
      $fatal(1, "Stopping at first error");
   endtask

   task automatic abort_run(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Some tests failed");
      $fatal(1, "Stopping at first error");
   endtask

   // Write checks
   a_wr_addr: assert property (@(posedge clk_i) disable iff (rst_i)
      wr_o.valid |-> wr_o.addr == exp_wr_addr)
      else report_mismatch("wr_o.addr", $sampled(wr_o.addr), exp_wr_addr);
   a_wr_data: assert property (@(posedge clk_i) disable iff (rst_i)
      wr_o.valid |-> wr_o.wdata == (exp_wr_addr ^ DATA_XOR))
      else report_mismatch("wr_o.wdata", $sampled(wr_o.wdata), exp_wr_addr ^ DATA_XOR);
   a_wr_strb: assert property (@(posedge clk_i) disable iff (rst_i)
      wr_o.valid |-> wr_o.wstrb == '1)
      else report_mismatch("wr_o.wstrb", 32'($sampled(wr_o.wstrb)), 32'hF);

   // Credit accounting, including the write on wr_o and a credit in flight
   a_credit_limit: assert property (@(posedge clk_i) disable iff (rst_i)
      outstanding + int'(wr_o.valid) + int'(credit_i) <= `WR_CREDITS)
      else report_mismatch("writes without credit",
                           32'(outstanding + int'($sampled(wr_o.valid))
                               + int'($sampled(credit_i))), `WR_CREDITS);
   a_credit_stall: assert property (@(posedge clk_i) disable iff (rst_i)
      outstanding + int'(wr_o.valid) + int'(credit_i) >= `WR_CREDITS |-> !rready_o)
      else report_mismatch("rready_o", 32'($sampled(rready_o)), 32'h0);

   // AR channel
   a_ar_addr: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_o.arvalid |-> ar_o.araddr == exp_base)
      else report_mismatch("ar_o.araddr", $sampled(ar_o.araddr), exp_base);
   a_ar_len: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_o.arvalid |-> ar_o.arlen == exp_len)
      else report_mismatch("ar_o.arlen", 32'($sampled(ar_o.arlen)), 32'(exp_len));
   a_ar_burst: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_o.arvalid |-> ar_o.arburst == axi_pkg::INCR)
      else report_mismatch("ar_o.arburst", 32'($sampled(ar_o.arburst)),
                           32'(axi_pkg::INCR));
   a_ar_size: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_o.arvalid |-> ar_o.arsize == 3'd2)
      else report_mismatch("ar_o.arsize", 32'($sampled(ar_o.arsize)), 32'd2);
   a_ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      ar_o.arvalid && !arready_i |=> ar_o.arvalid)
      else report_mismatch("ar_o.arvalid", 32'($sampled(ar_o.arvalid)), 32'h1);

   a_ready_drop: assert property (@(posedge clk_i) disable iff (rst_i)
      run_i && ready_o |=> !ready_o)
      else report_mismatch("ready_o", 32'($sampled(ready_o)), 32'h0);

   // Sink consumes writes and returns credits after a random delay
   always begin
      @(negedge clk_i);
      wr_seen     = wr_o.valid && !rst_i;
      give_credit = (outstanding + int'(wr_seen) > 0) && !hold_credits
                    && (next_rand() % 3 != 0);
      @(posedge clk_i);
      #2;
      credit_i = give_credit;
      if (wr_seen) begin
         wr_idx++;
         outstanding++;
      end
      if (give_credit) begin
         outstanding--;
      end
   end

   task automatic wait_ready();
      int cycles;
      cycles = 0;
      while (!ready_o) begin
         @(posedge clk_i);
         #2;
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            abort_run("timeout waiting for ready_o to return high");
         end
      end
   endtask

   task automatic run_burst(input logic [`AXI_ADDR_W-1:0] base,
                            input logic [`AXI_LEN_W-1:0] len, input logic exp_err);
      wait_ready();
      exp_base = base;
      exp_len  = len;
      wr_idx   = 0;
      req_i    = '{addr: base, len: len};
      run_i    = 1'b1;
      @(posedge clk_i);
      #2;
      run_i = 1'b0;
      wait_ready();
      // Last write shows on wr_o the cycle ready_o rises
      repeat (2) @(posedge clk_i);
      #2;
      a_wr_count: assert (wr_idx == int'(len) + 1)
         else report_mismatch("write count", 32'(wr_idx), 32'(len) + 1);
      a_error: assert (error_o == exp_err)
         else report_mismatch("error_o", 32'(error_o), 32'(exp_err));
   endtask

   task automatic release_credits_later(input int cycles);
      repeat (cycles) @(posedge clk_i);
      #2;
      hold_credits = 1'b0;
   endtask

   initial begin
      clk_i        = 1'b0;
      rst_i        = 1'b1;
      run_i        = 1'b0;
      req_i        = '0;
      credit_i     = 1'b0;
      err_en       = 1'b0;
      err_beat     = '0;
      drop_last    = 1'b0;
      hold_credits = 1'b0;
      rand_state   = 57831;
      wr_idx       = 0;
      outstanding  = 0;
      exp_base     = '0;
      exp_len      = '0;
      repeat (4) @(posedge clk_i);
      #2;
      rst_i = 1'b0;

      a_reset_ready: assert (ready_o)
         else report_mismatch("ready_o", 32'(ready_o), 32'h1);
      a_reset_arvalid: assert (!ar_o.arvalid)
         else report_mismatch("ar_o.arvalid", 32'(ar_o.arvalid), 32'h0);
      a_reset_rready: assert (!rready_o)
         else report_mismatch("rready_o", 32'(rready_o), 32'h0);
      a_reset_wr_valid: assert (!wr_o.valid)
         else report_mismatch("wr_o.valid", 32'(wr_o.valid), 32'h0);

      run_burst(32'h0000_1000, 8'd0, 1'b0);
      run_burst(32'h0000_2040, 8'd7, 1'b0);

      // Random clean bursts
      for (int i = 0; i < 8; i++) begin
         run_burst((next_rand() & 32'h0000_FFF0) << 2, 8'(next_rand() % 16), 1'b0);
      end

      // Credits withheld while R data is offered
      hold_credits = 1'b1;
      fork
         run_burst(32'h0001_0000, 8'd11, 1'b0);
         release_credits_later(30);
      join

      // Error response on one beat, then a clean burst
      err_en   = 1'b1;
      err_beat = 8'd2;
      run_burst(32'h0002_0000, 8'd5, 1'b1);
      err_en = 1'b0;
      run_burst(32'h0002_0100, 8'd3, 1'b0);

      // Missing rlast, then a clean burst
      drop_last = 1'b1;
      run_burst(32'h0003_0000, 8'd4, 1'b1);
      drop_last = 1'b0;
      run_burst(32'h0003_0200, 8'd2, 1'b0);

      $display("All tests passed");
      $finish;
   end

endmodule

//--- axi_rd_dma.f
+incdir+rtl
rtl/axi_pkg.sv
rtl/xfer_pkg.sv
rtl/rd_burst_ctrl.sv
rtl/ar_channel.sv
rtl/wr_addr_gen.sv
rtl/credit_counter.sv
rtl/axi_rd_dma.sv
verif/axi_mem_model.sv
verif/tb_axi_rd_dma.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the read-burst engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_axi_rd_dma \
   -f axi_rd_dma.f \
   -o sim_axi_rd_dma
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_axi_rd_dma 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -q "^All tests passed$"; then
   exit 0
fi
exit 1
